// File: logic/tile_render_pkg.sv
package tile_render_pkg;

  // --------------------
  // map tiles
  // --------------------
  typedef enum logic [1:0] {
    NO_BLK,
    PERM_BLK,
    DESTROYABLE_BLK,
    BOMB
  } tile_state_t;

  localparam int MAP_ADDR_W = 8;
  typedef logic [MAP_ADDR_W-1:0] tile_addr_t;

  // --------------------
  // pixels and colours
  // --------------------
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb12_t;

  typedef logic [10:0] coord_x_t;
  typedef logic [9:0]  coord_y_t;

  // scanner to shader, 30 bits
  typedef struct packed {
    coord_x_t   x;
    coord_y_t   y;
    logic       in_map;  // low for border pixels
    tile_addr_t tile_addr;
  } pix_req_t;

  // shader to output, 33 bits
  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    rgb12_t   rgb;
  } pix_out_t;

  // flat palette
  localparam rgb12_t COLOR_BORDER = 12'h000;
  localparam rgb12_t COLOR_BG     = 12'h173;
  localparam rgb12_t COLOR_PERM   = 12'h888;
  localparam rgb12_t COLOR_DEST   = 12'hA52;
  localparam rgb12_t COLOR_BOMB   = 12'h222;
  localparam rgb12_t COLOR_EXPL   = 12'hF80;
  localparam rgb12_t COLOR_ERROR  = 12'hF0F;  // should never show up

endpackage

// File: logic/raster_scanner.sv
module raster_scanner #(
  parameter int NUM_COL  = 4,
  parameter int NUM_ROW  = 3,
  parameter int BLK_LOG2 = 3,
  parameter int HUD_SIDE = 4,
  parameter int HUD_TOP  = 8,
  parameter int HUD_BOT  = 4
) (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_start,
  output logic                      o_busy,
  output logic                      o_req_valid,
  input  logic                      i_req_ready,
  output tile_render_pkg::pix_req_t o_req
);
  import tile_render_pkg::*;

  localparam int BLK_SIZE  = 1 << BLK_LOG2;
  localparam int SCREEN_W  = 2 * HUD_SIDE + NUM_COL * BLK_SIZE;
  localparam int SCREEN_H  = HUD_TOP + HUD_BOT + NUM_ROW * BLK_SIZE;
  localparam int MAP_DEPTH = NUM_COL * NUM_ROW;

  coord_x_t   x_cnt;
  coord_y_t   y_cnt;
  logic       running;
  logic       last_x;
  logic       last_y;
  logic       xfer;
  logic       border;
  coord_x_t   map_x;
  coord_y_t   map_y;
  coord_x_t   col;
  coord_y_t   row;
  tile_addr_t tile_addr;

  // --------------------
  // raster walk
  // --------------------
  assign last_x = (x_cnt == coord_x_t'(SCREEN_W - 1));
  assign last_y = (y_cnt == coord_y_t'(SCREEN_H - 1));
  assign xfer   = running && i_req_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      running <= 1'b0;
      x_cnt   <= '0;
      y_cnt   <= '0;
    end else if (!running) begin
      if (i_start) begin  // start only counts while idle
        running <= 1'b1;
        x_cnt   <= '0;
        y_cnt   <= '0;
      end
    end else if (xfer) begin
      if (last_x) begin
        x_cnt <= '0;
        if (last_y) begin
          running <= 1'b0;  // frame fully handed off
          y_cnt   <= '0;
        end else begin
          y_cnt <= y_cnt + 1'b1;
        end
      end else begin
        x_cnt <= x_cnt + 1'b1;
      end
    end
  end

  // --------------------
  // pixel classification
  // --------------------
  assign border = (x_cnt <  coord_x_t'(HUD_SIDE))            ||
                  (x_cnt >= coord_x_t'(SCREEN_W - HUD_SIDE)) ||
                  (y_cnt <  coord_y_t'(HUD_TOP))             ||
                  (y_cnt >= coord_y_t'(SCREEN_H - HUD_BOT));

  // offsets from the playfield origin
  assign map_x = x_cnt - coord_x_t'(HUD_SIDE);
  assign map_y = y_cnt - coord_y_t'(HUD_TOP);
  assign col   = map_x >> BLK_LOG2;
  assign row   = map_y >> BLK_LOG2;

  assign tile_addr = border ? '0 : tile_addr_t'(row * NUM_COL + col);

  always_comb begin
    o_req.x         = x_cnt;
    o_req.y         = y_cnt;
    o_req.in_map    = !border;
    o_req.tile_addr = tile_addr;
  end

  assign o_req_valid = running;
  assign o_busy      = running;

  a_addr_in_map: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_req_valid |-> (o_req.tile_addr < MAP_DEPTH))
    else $error("tile address %0d outside the map", o_req.tile_addr);

endmodule

// File: logic/stream_fifo.sv
module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data,
  output logic     o_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_ready = (count != CNT_W'(DEPTH));  // full blocks the writer
  assign o_valid = (count != '0);
  assign o_empty = (count == '0);
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_data;
  end

  assign o_data = mem[rd_ptr];

  a_count_max: assert property (@(posedge clk) disable iff (!i_rst_n)
    count <= CNT_W'(DEPTH))
    else $error("fifo count above depth");

  // head entry must not move while the reader stalls
  a_head_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> $stable(o_data))
    else $error("fifo head changed under stall");

endmodule

// File: logic/tile_shader.sv
module tile_shader #(
  parameter int NUM_COL = 4,
  parameter int NUM_ROW = 3
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic                         i_req_valid,
  output logic                         o_req_ready,
  input  tile_render_pkg::pix_req_t    i_req,
  input  logic                         i_map_we,
  input  tile_render_pkg::tile_addr_t  i_map_waddr,
  input  tile_render_pkg::tile_state_t i_map_wdata,
  input  logic                         i_expl_valid,
  input  tile_render_pkg::tile_addr_t  i_expl_addr,
  output logic                         o_pix_valid,
  input  logic                         i_pix_ready,
  output tile_render_pkg::pix_out_t    o_pix,
  output logic                         o_idle
);
  import tile_render_pkg::*;

  localparam int MAP_DEPTH = NUM_COL * NUM_ROW;
  localparam int MEM_AW    = (MAP_DEPTH > 1) ? $clog2(MAP_DEPTH) : 1;

  tile_state_t map_mem [MAP_DEPTH];

  logic        s1_valid;
  pix_req_t    s1_req;
  tile_state_t rd_state;  // synchronous read result, lines up with s1_req
  logic        s2_valid;
  pix_out_t    s2_pix;
  logic        s1_move;
  logic        s2_move;
  logic        pop;
  logic        blast;
  rgb12_t      pix_rgb;

  // plus shape around the centre, plain address arithmetic so +-1 wraps rows
  function automatic logic in_blast(input tile_addr_t addr, input tile_addr_t ctr);
    return (addr == ctr)                        ||
           (addr == tile_addr_t'(ctr + 1))       ||
           (addr == tile_addr_t'(ctr - 1))       ||
           (addr == tile_addr_t'(ctr + NUM_COL)) ||
           (addr == tile_addr_t'(ctr - NUM_COL));
  endfunction

  // --------------------
  // pipeline control
  // --------------------
  assign s2_move     = !s2_valid || i_pix_ready;
  assign s1_move     = !s1_valid || s2_move;  // stage 1 waits on stage 2
  assign pop         = i_req_valid && s1_move;
  assign o_req_ready = s1_move;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_move) s1_valid <= i_req_valid;
      if (s2_move) s2_valid <= s1_valid;
    end
  end

  // --------------------
  // map memory, stage 1
  // --------------------
  // a write in the same cycle as a read returns the old state
  always_ff @(posedge clk) begin
    if (i_map_we && (i_map_waddr < MAP_DEPTH)) begin
      map_mem[i_map_waddr[MEM_AW-1:0]] <= i_map_wdata;
    end
    if (pop) begin
      s1_req   <= i_req;
      rd_state <= map_mem[i_req.tile_addr[MEM_AW-1:0]];
    end
  end

  // --------------------
  // colour, stage 2
  // --------------------
  always_comb begin
    blast = i_expl_valid && in_blast(s1_req.tile_addr, i_expl_addr);
    if (!s1_req.in_map) begin
      pix_rgb = COLOR_BORDER;
    end else begin
      case (rd_state)
        NO_BLK:          pix_rgb = blast ? COLOR_EXPL : COLOR_BG;
        PERM_BLK:        pix_rgb = COLOR_PERM;
        DESTROYABLE_BLK: pix_rgb = blast ? COLOR_EXPL : COLOR_DEST;
        BOMB:            pix_rgb = COLOR_BOMB;  // bombs are not blasted away here
        default:         pix_rgb = COLOR_ERROR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s2_move && s1_valid) begin
      s2_pix.x   <= s1_req.x;
      s2_pix.y   <= s1_req.y;
      s2_pix.rgb <= pix_rgb;
    end
  end

  assign o_pix_valid = s2_valid;
  assign o_pix       = s2_pix;
  assign o_idle      = !s1_valid && !s2_valid;

  a_s2_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    (s2_valid && !i_pix_ready) |=> (s2_valid && $stable(o_pix)))
    else $error("stage 2 pixel changed under back-pressure");

endmodule

// File: logic/tile_renderer.sv
module tile_renderer #(
  parameter int NUM_COL    = 4,
  parameter int NUM_ROW    = 3,
  parameter int BLK_LOG2   = 3,
  parameter int HUD_SIDE   = 4,
  parameter int HUD_TOP    = 8,
  parameter int HUD_BOT    = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic                         i_start,
  // map write port
  input  logic                         i_map_we,
  input  tile_render_pkg::tile_addr_t  i_map_waddr,
  input  tile_render_pkg::tile_state_t i_map_wdata,
  // explosion centre
  input  logic                         i_expl_valid,
  input  tile_render_pkg::tile_addr_t  i_expl_addr,
  // pixel stream
  output logic                         o_pix_valid,
  input  logic                         i_pix_ready,
  output tile_render_pkg::coord_x_t    o_pix_x,
  output tile_render_pkg::coord_y_t    o_pix_y,
  output tile_render_pkg::rgb12_t      o_pix_rgb,
  output logic                         o_busy
);
  import tile_render_pkg::*;

  if (NUM_COL * NUM_ROW > (1 << MAP_ADDR_W)) begin : g_map_fit
    $error("map of %0d tiles does not fit the tile address", NUM_COL * NUM_ROW);
  end

  logic     scan_busy;
  logic     req_valid;
  logic     req_ready;
  pix_req_t req_data;
  logic     qreq_valid;
  logic     qreq_ready;
  pix_req_t qreq_data;
  logic     req_empty;
  logic     pix_valid;
  logic     pix_ready;
  pix_out_t pix_data;
  pix_out_t out_data;
  logic     out_empty;
  logic     shader_idle;

  // --------------------
  // producer
  // --------------------
  raster_scanner #(
    .NUM_COL (NUM_COL),
    .NUM_ROW (NUM_ROW),
    .BLK_LOG2(BLK_LOG2),
    .HUD_SIDE(HUD_SIDE),
    .HUD_TOP (HUD_TOP),
    .HUD_BOT (HUD_BOT)
  ) raster_scanner_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_start    (i_start),
    .o_busy     (scan_busy),
    .o_req_valid(req_valid),
    .i_req_ready(req_ready),
    .o_req      (req_data)
  );

  stream_fifo #(
    .payload_t(pix_req_t),
    .DEPTH    (FIFO_DEPTH)
  ) req_fifo_i (
    .clk    (clk),
    .i_rst_n(i_rst_n),
    .i_valid(req_valid),
    .o_ready(req_ready),
    .i_data (req_data),
    .o_valid(qreq_valid),
    .i_ready(qreq_ready),
    .o_data (qreq_data),
    .o_empty(req_empty)
  );

  // --------------------
  // consumer
  // --------------------
  tile_shader #(
    .NUM_COL(NUM_COL),
    .NUM_ROW(NUM_ROW)
  ) tile_shader_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req_valid (qreq_valid),
    .o_req_ready (qreq_ready),
    .i_req       (qreq_data),
    .i_map_we    (i_map_we),
    .i_map_waddr (i_map_waddr),
    .i_map_wdata (i_map_wdata),
    .i_expl_valid(i_expl_valid),
    .i_expl_addr (i_expl_addr),
    .o_pix_valid (pix_valid),
    .i_pix_ready (pix_ready),
    .o_pix       (pix_data),
    .o_idle      (shader_idle)
  );

  stream_fifo #(
    .payload_t(pix_out_t),
    .DEPTH    (FIFO_DEPTH)
  ) out_fifo_i (
    .clk    (clk),
    .i_rst_n(i_rst_n),
    .i_valid(pix_valid),
    .o_ready(pix_ready),
    .i_data (pix_data),
    .o_valid(o_pix_valid),
    .i_ready(i_pix_ready),
    .o_data (out_data),
    .o_empty(out_empty)
  );

  assign o_pix_x   = out_data.x;
  assign o_pix_y   = out_data.y;
  assign o_pix_rgb = out_data.rgb;

  // frame still draining anywhere along the chain
  assign o_busy = scan_busy || !req_empty || !shader_idle || !out_empty;

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;  // first rising edge at half a period
  end

endmodule

// File: verif/tb_tile_renderer.sv
module tb_tile_renderer;
  import tile_render_pkg::*;

  localparam int NUM_COL    = 4;
  localparam int NUM_ROW    = 3;
  localparam int BLK_LOG2   = 3;
  localparam int HUD_SIDE   = 4;
  localparam int HUD_TOP    = 8;
  localparam int HUD_BOT    = 4;
  localparam int FIFO_DEPTH = 4;

  localparam int SCREEN_W   = 2 * HUD_SIDE + (NUM_COL << BLK_LOG2);  // 40
  localparam int SCREEN_H   = HUD_TOP + HUD_BOT + (NUM_ROW << BLK_LOG2);  // 36
  localparam int FRAME_PIX  = SCREEN_W * SCREEN_H;
  localparam int MAP_DEPTH  = NUM_COL * NUM_ROW;
  localparam int NUM_FRAMES = 6;
  localparam int FRAME_TIMEOUT = 20 * FRAME_PIX;  // cycles
  localparam int IDLE_TIMEOUT  = 100;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        map_we;
  tile_addr_t  map_waddr;
  tile_state_t map_wdata;
  logic        expl_valid;
  tile_addr_t  expl_addr;
  logic        pix_valid;
  logic        pix_ready;
  coord_x_t    pix_x;
  coord_y_t    pix_y;
  rgb12_t      pix_rgb;
  logic        busy;

  tile_state_t model_map [MAP_DEPTH];  // what the testbench wrote into the map
  int          mismatch_count;
  int          timeout_count;
  bit          timed_out;

  tb_clock_gen #(
    .PERIOD(8)
  ) clock_gen_i (
    .clk(clk)
  );

  tile_renderer #(
    .NUM_COL   (NUM_COL),
    .NUM_ROW   (NUM_ROW),
    .BLK_LOG2  (BLK_LOG2),
    .HUD_SIDE  (HUD_SIDE),
    .HUD_TOP   (HUD_TOP),
    .HUD_BOT   (HUD_BOT),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) tile_renderer_i (
    .clk         (clk),
    .i_rst_n     (rst_n),
    .i_start     (start),
    .i_map_we    (map_we),
    .i_map_waddr (map_waddr),
    .i_map_wdata (map_wdata),
    .i_expl_valid(expl_valid),
    .i_expl_addr (expl_addr),
    .o_pix_valid (pix_valid),
    .i_pix_ready (pix_ready),
    .o_pix_x     (pix_x),
    .o_pix_y     (pix_y),
    .o_pix_rgb   (pix_rgb),
    .o_busy      (busy)
  );

  // --------------------
  // reference model
  // --------------------
  // plus shape on 8-bit tile addresses, so the side neighbours wrap
  function automatic bit in_plus(input int addr, input int ctr);
    return (addr == ctr) ||
           (addr == (ctr + 1) % 256) ||
           (addr == (ctr + 255) % 256) ||
           (addr == (ctr + NUM_COL) % 256) ||
           (addr == (ctr + 256 - NUM_COL) % 256);
  endfunction

  function automatic rgb12_t expected_rgb(input int x, input int y, input bit blast_on,
                                          input int ctr);
    int          col;
    int          row;
    int          addr;
    bit          blast;
    tile_state_t state;
    if (x < HUD_SIDE || x >= SCREEN_W - HUD_SIDE || y < HUD_TOP || y >= SCREEN_H - HUD_BOT) begin
      return COLOR_BORDER;
    end
    col   = (x - HUD_SIDE) >> BLK_LOG2;
    row   = (y - HUD_TOP) >> BLK_LOG2;
    addr  = row * NUM_COL + col;
    state = model_map[addr];
    blast = blast_on && in_plus(addr, ctr);
    case (state)
      PERM_BLK:        return COLOR_PERM;
      BOMB:            return COLOR_BOMB;
      DESTROYABLE_BLK: return blast ? COLOR_EXPL : COLOR_DEST;
      default:         return blast ? COLOR_EXPL : COLOR_BG;
    endcase
  endfunction

  // --------------------
  // checks and stimulus
  // --------------------
  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic setup_frame(input int frame);
    tile_state_t state;
    for (int a = 0; a < MAP_DEPTH; a++) begin
      @(negedge clk);
      state        = tile_state_t'($urandom_range(0, 3));
      map_we       = 1'b1;
      map_waddr    = tile_addr_t'(a);
      map_wdata    = state;
      model_map[a] = state;
    end
    @(negedge clk);
    map_we = 1'b0;
    // first two frames cover both cases, the rest are random
    if (frame == 0) expl_valid = 1'b1;
    else if (frame == 1) expl_valid = 1'b0;
    else expl_valid = 1'($urandom_range(0, 1));
    expl_addr = tile_addr_t'($urandom_range(0, MAP_DEPTH - 1));
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value(busy, 1'b1, "busy after start");
  endtask

  task automatic collect_frame(input int frame);
    int     exp_x;
    int     exp_y;
    int     count;
    int     cycles;
    rgb12_t exp_rgb;
    exp_x  = 0;
    exp_y  = 0;
    count  = 0;
    cycles = 0;
    while (count < FRAME_PIX && !timed_out) begin
      @(negedge clk);
      pix_ready = ($urandom_range(0, 3) != 0);  // about one stall in four
      if (pix_valid && pix_ready) begin  // taken at the next rising edge
        exp_rgb = expected_rgb(exp_x, exp_y, expl_valid, int'(expl_addr));
        check_value(pix_x, exp_x, $sformatf("x of pixel %0d", count));
        check_value(pix_y, exp_y, $sformatf("y of pixel %0d", count));
        check_value(pix_rgb, exp_rgb, $sformatf("colour at (%0d,%0d)", exp_x, exp_y));
        if (!expl_valid) begin
          check_value(pix_rgb == COLOR_EXPL, 1'b0, "explosion colour without explosion");
        end
        count++;
        if (exp_x == SCREEN_W - 1) begin
          exp_x = 0;
          exp_y++;
        end else begin
          exp_x++;
        end
      end
      cycles++;
      if (count < FRAME_PIX && cycles >= FRAME_TIMEOUT) begin
        $display("timeout: frame %0d gave only %0d of %0d pixels in %0d cycles",
                 frame, count, FRAME_PIX, cycles);
        timeout_count++;
        timed_out = 1'b1;
      end
    end
  endtask

  // no pixel may follow the frame, and busy has to fall
  task automatic wait_frame_end(input int frame);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      pix_ready = 1'b0;
      check_value(pix_valid, 1'b0, $sformatf("extra pixel after frame %0d", frame));
      cycles++;
      if (busy && cycles >= IDLE_TIMEOUT) begin
        $display("timeout: busy still high %0d cycles after frame %0d", cycles, frame);
        timeout_count++;
        timed_out = 1'b1;
      end
    end while (busy && !timed_out);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    void'($urandom(32'h665d));
    rst_n          = 1'b0;
    start          = 1'b0;
    map_we         = 1'b0;
    map_waddr      = '0;
    map_wdata      = NO_BLK;
    expl_valid     = 1'b0;
    expl_addr      = '0;
    pix_ready      = 1'b0;
    mismatch_count = 0;
    timeout_count  = 0;
    timed_out      = 1'b0;

    repeat (3) @(posedge clk);  // reset held over three rising edges
    @(negedge clk);
    rst_n = 1'b1;
    check_value(busy, 1'b0, "busy after reset");
    check_value(pix_valid, 1'b0, "pixel valid after reset");

    for (int frame = 0; frame < NUM_FRAMES && !timed_out; frame++) begin
      setup_frame(frame);
      pulse_start();
      collect_frame(frame);
      if (!timed_out) wait_frame_end(frame);
      $display("frame %0d done, explosion %0b at tile %0d", frame, expl_valid, expl_addr);
    end

    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
logic/tile_render_pkg.sv
logic/raster_scanner.sv
logic/stream_fifo.sv
logic/tile_shader.sv
logic/tile_renderer.sv
verif/tb_clock_gen.sv
verif/tb_tile_renderer.sv

// File: Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_renderer \
		-f src.f -Mdir obj_dir
	./obj_dir/Vtb_tile_renderer | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
